// File: Makefile
VERILATOR ?= verilator
TOP       ?= timing_tb
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
SIM_NAME  ?= timing_sim
LOG       ?= sim.log
VFLAGS    ?= --binary --assert --timing
RUN_FLAGS ?= +verilator+error+limit+1000

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o $(SIM_NAME)

run: build
	-./$(OBJ_DIR)/$(SIM_NAME) $(RUN_FLAGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TEST FAIL" $(LOG); then exit 1; fi
	@grep -q "TEST PASS" $(LOG)

lint:
	$(VERILATOR) --lint-only -Wall --assert --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: hw/control_pkg.sv
package control_pkg;

    typedef enum logic [1:0] {
        pa,
        pb,
        pc
    } prog_phase_t;

    typedef enum logic [2:0] {
        rec_idle,
        rec_exec,
        rec_a,
        rec_b,
        rec_c
    } rec_state_t;

    typedef struct packed {
        logic valid;
        logic ccfh_in;
    } exec_req_t;

    typedef struct packed {
        logic [timing_pkg::gate_count-1:0] g;
        logic                              ad;
        prog_phase_t                       prog_phase;
        rec_state_t                        rec_state;
        logic                              rexc;
        logic                              ccfh;
        logic                              word_done;
        logic                              w;        // Slot strobes, one-hot.
        logic                              x;
        logic                              y;
        logic                              z;
    } timing_status_t;

endpackage

// File: hw/gate_ring.sv
module gate_ring (
    input  logic                      sim_clk,
    input  logic                      reset,
    input  timing_pkg::phase_strobe_t strobe,
    output timing_pkg::gate_t         gate
);
    import timing_pkg::*;

    logic [gate_count-1:0] ring;
    logic                  word_done;
    logic                  step;
    logic                  wrap;

    // The ring moves once every two bit times.
    assign step = strobe.w && strobe.ad;
    assign wrap = step && ring[gate_count-1];      // g7 back to g1.

    always_ff @(posedge sim_clk) begin
        if (reset) begin
            ring <= {{(gate_count-1){1'b0}}, 1'b1};
        end else if (step) begin
            ring <= {ring[gate_count-2:0], ring[gate_count-1]};
        end
    end

    always_ff @(posedge sim_clk) begin
        if (reset) begin
            word_done <= 1'b0;
        end else begin
            word_done <= wrap;                       // Lands in the x slot.
        end
    end

    assign gate.g         = ring;
    assign gate.word_done = word_done;

endmodule

// File: hw/phase_gen.sv
module phase_gen (
    input  logic                      sim_clk,
    input  logic                      reset,
    output timing_pkg::phase_strobe_t strobe
);
    import timing_pkg::*;

    slot_t slot;
    logic  ad;
    logic  last_slot;

    assign last_slot = (slot == slot_t'(slots_per_bit - 1));

    always_ff @(posedge sim_clk) begin
        if (reset) begin
            slot <= w_slot;
            ad   <= 1'b0;
        end else begin
            slot <= last_slot ? w_slot : slot_t'(slot + 2'd1);
            if (last_slot) begin
                ad <= ~ad;                           // New bit time starts.
            end
        end
    end

    // Slot decode.
    assign strobe.w  = (slot == w_slot);
    assign strobe.x  = (slot == x_slot);
    assign strobe.y  = (slot == y_slot);
    assign strobe.z  = (slot == z_slot);
    assign strobe.ad = ad;

endmodule

// File: hw/program_phase.sv
module program_phase (
    input  logic                      sim_clk,
    input  logic                      reset,
    input  logic                      hold,
    input  logic                      word_done,
    output control_pkg::prog_phase_t  phase
);
    import control_pkg::*;

    prog_phase_t phase_next;

    always_comb begin
        case (phase)
            pa:      phase_next = pb;
            pb:      phase_next = pc;
            pc:      phase_next = pa;
            default: phase_next = pa;
        endcase
    end

    always_ff @(posedge sim_clk) begin
        if (reset) begin
            phase <= pa;
        end else if (word_done && !hold) begin
            phase <= phase_next;                     // Step at the word boundary.
        end
    end

endmodule

// File: hw/record_ctl.sv
module record_ctl (
    input  logic                      sim_clk,
    input  logic                      reset,
    input  timing_pkg::phase_strobe_t strobe,
    input  logic                      g2,
    input  control_pkg::prog_phase_t  phase,
    input  control_pkg::exec_req_t    exec_req,
    output logic                      exec_ready,
    output control_pkg::rec_state_t   rec_state,
    output logic                      rexc,
    output logic                      ccfh
);
    import control_pkg::*;

    logic transfer;
    logic ccfh_rec;

    // Accept only in the y slot of g2 during pc.
    assign exec_ready = strobe.y && g2 && (phase == pc) && (rec_state == rec_idle);
    assign transfer   = exec_req.valid && exec_ready;

    always_ff @(posedge sim_clk) begin
        if (transfer) begin
            ccfh_rec <= exec_req.ccfh_in;
        end
    end

    always_ff @(posedge sim_clk) begin
        if (reset) begin
            rec_state <= rec_idle;
            rexc      <= 1'b0;
            ccfh      <= 1'b0;
        end else begin
            case (rec_state)
                rec_idle: begin
                    if (transfer) begin
                        rec_state <= rec_exec;
                        rexc      <= 1'b1;
                    end
                end
                rec_exec: begin
                    if (strobe.z) begin
                        rec_state <= rec_a;
                    end
                end
                rec_a: begin
                    if (strobe.z) begin
                        rec_state <= rec_b;
                    end
                end
                rec_b: begin
                    if (strobe.z) begin
                        rec_state <= rec_c;
                    end
                end
                rec_c: begin
                    if (strobe.x) begin
                        ccfh <= ccfh_rec;            // Held until the next rec_c.
                    end
                    if (strobe.z) begin
                        rec_state <= rec_idle;
                        rexc      <= 1'b0;
                    end
                end
                default: begin
                    rec_state <= rec_idle;
                    rexc      <= 1'b0;
                end
            endcase
        end
    end

endmodule

// File: hw/timing_pkg.sv
package timing_pkg;

    localparam int slots_per_bit = 4;                // sim_clk cycles per bit time.
    localparam int gate_count = 7;                   // Positions g1 to g7.

    typedef enum logic [1:0] {
        w_slot,
        x_slot,
        y_slot,
        z_slot
    } slot_t;

    // One-hot slot strobes plus the half-step flag.
    typedef struct packed {
        logic w;
        logic x;
        logic y;
        logic z;
        logic ad;
    } phase_strobe_t;

    typedef struct packed {
        logic [gate_count-1:0] g;                    // Bit 0 is g1.
        logic                  word_done;
    } gate_t;

endpackage

// File: hw/timing_top.sv
module timing_top (
    input  logic                        sim_clk,
    input  logic                        reset,
    input  logic                        hold,
    input  control_pkg::exec_req_t      exec_req,
    output logic                        exec_ready,
    output control_pkg::timing_status_t status
);
    import timing_pkg::*;
    import control_pkg::*;

    phase_strobe_t strobe;
    gate_t         gate;
    prog_phase_t   phase;
    rec_state_t    rec_state;
    logic          rexc;
    logic          ccfh;

    phase_gen u_phase_gen (
        .sim_clk (sim_clk),
        .reset   (reset),
        .strobe  (strobe)
    );

    gate_ring u_gate_ring (
        .sim_clk (sim_clk),
        .reset   (reset),
        .strobe  (strobe),
        .gate    (gate)
    );

    program_phase u_program_phase (
        .sim_clk   (sim_clk),
        .reset     (reset),
        .hold      (hold),
        .word_done (gate.word_done),
        .phase     (phase)
    );

    record_ctl u_record_ctl (
        .sim_clk    (sim_clk),
        .reset      (reset),
        .strobe     (strobe),
        .g2         (gate.g[1]),
        .phase      (phase),
        .exec_req   (exec_req),
        .exec_ready (exec_ready),
        .rec_state  (rec_state),
        .rexc       (rexc),
        .ccfh       (ccfh)
    );

    assign status.g          = gate.g;
    assign status.ad         = strobe.ad;
    assign status.prog_phase = phase;
    assign status.rec_state  = rec_state;
    assign status.rexc       = rexc;
    assign status.ccfh       = ccfh;
    assign status.word_done  = gate.word_done;
    assign status.w          = strobe.w;
    assign status.x          = strobe.x;
    assign status.y          = strobe.y;
    assign status.z          = strobe.z;

endmodule

// File: project.f
hw/timing_pkg.sv
hw/control_pkg.sv
hw/phase_gen.sv
hw/gate_ring.sv
hw/program_phase.sv
hw/record_ctl.sv
hw/timing_top.sv
verification/tb_clock.sv
verification/timing_assertions.sv
verification/timing_tb.sv

// File: verification/tb_clock.sv
module tb_clock (
    output logic sim_clk,
    output logic reset
);

    initial begin
        sim_clk = 1'b0;
        reset   = 1'b1;
        repeat (3) @(posedge sim_clk);
        #1 reset = 1'b0;                             // Released just after the third edge.
    end

    always #4 sim_clk = ~sim_clk;

endmodule

// File: verification/timing_assertions.sv
module timing_assertions (
    input logic                        sim_clk,
    input logic                        reset,
    input logic                        hold,
    input control_pkg::exec_req_t      exec_req,
    input logic                        exec_ready,
    input control_pkg::timing_status_t status
);
    import control_pkg::*;

    int         fail_count = 0;
    int         word_gap;
    logic       word_seen;
    logic       ccfh_accepted;
    logic [3:0] slots;
    logic [6:0] g_rot;
    logic       step;
    logic       transfer;
    rec_state_t rec_expect;

    assign slots    = {status.w, status.x, status.y, status.z};
    assign g_rot    = {status.g[5:0], status.g[6]};  // One ring position further.
    assign step     = status.w && status.ad;
    assign transfer = exec_req.valid && exec_ready;

    function automatic prog_phase_t phase_after(input prog_phase_t p);
        return (p == pa) ? pb : (p == pb) ? pc : pa;
    endfunction

    function automatic rec_state_t rec_after(input rec_state_t s);
        return (s == rec_exec) ? rec_a : (s == rec_a) ? rec_b :
               (s == rec_b) ? rec_c : rec_idle;
    endfunction

    // Idle waits for a transfer, busy states step on z.
    assign rec_expect = (status.rec_state == rec_idle) ? (transfer ? rec_exec : rec_idle)
                      : status.z ? rec_after(status.rec_state) : status.rec_state;

    always_ff @(posedge sim_clk) begin
        if (reset) begin
            word_seen <= 1'b0;
            word_gap  <= 0;
        end else if (status.word_done) begin
            word_seen <= 1'b1;
            word_gap  <= 1;
        end else begin
            word_gap <= word_gap + 1;
        end
        if (transfer) begin
            ccfh_accepted <= exec_req.ccfh_in;
        end
    end

    a_reset_state: assert property (@(posedge sim_clk) $fell(reset) |-> status.w && !status.ad
        && status.g == 7'b0000001 && status.prog_phase == pa && status.rec_state == rec_idle
        && !status.rexc && !status.ccfh && !status.word_done && !exec_ready)
    else begin
        fail_count++;
        $error("state after reset is not w, g1, pa, idle");
    end

    a_slot_ad: assert property (@(posedge sim_clk) disable iff (reset)
        1'b1 |=> $onehot(slots) && slots == {$past(slots[0]), $past(slots[3:1])}
        && status.ad == ($past(status.z) ? !$past(status.ad) : $past(status.ad)))
    else begin
        fail_count++;
        $error("slot order or ad toggle is wrong");
    end

    a_gate_word: assert property (@(posedge sim_clk) disable iff (reset)
        1'b1 |=> $onehot(status.g) && status.g == ($past(step) ? $past(g_rot) : $past(status.g))
        && status.word_done == $past(step && status.g[6]))
    else begin
        fail_count++;
        $error("gate ring step or word_done pulse is wrong");
    end

    a_word_len: assert property (@(posedge sim_clk) disable iff (reset)
        status.word_done && word_seen |-> word_gap == 56)
    else begin
        fail_count++;
        $error("word length is not 56 cycles");
    end

    a_phase: assert property (@(posedge sim_clk) disable iff (reset)
        1'b1 |=> status.prog_phase == ($past(status.word_done && !hold) ?
        phase_after($past(status.prog_phase)) : $past(status.prog_phase)))
    else begin
        fail_count++;
        $error("program phase stepped wrongly");
    end

    a_ready: assert property (@(posedge sim_clk) disable iff (reset)
        exec_ready == (status.y && status.g[1] && status.prog_phase == pc
        && status.rec_state == rec_idle))
    else begin
        fail_count++;
        $error("exec_ready outside y, g2, pc and idle");
    end

    a_record: assert property (@(posedge sim_clk) disable iff (reset)
        1'b1 |=> status.rec_state == $past(rec_expect)
        && status.rexc == (status.rec_state != rec_idle))
    else begin
        fail_count++;
        $error("record chain or rexc is wrong");
    end

    a_ccfh: assert property (@(posedge sim_clk) disable iff (reset)
        1'b1 |=> status.ccfh == ($past(status.rec_state == rec_c && status.x) ?
        $past(ccfh_accepted) : $past(status.ccfh)))
    else begin
        fail_count++;
        $error("ccfh does not match the accepted value");
    end

endmodule

bind timing_top timing_assertions u_timing_assertions (
    .sim_clk    (sim_clk),
    .reset      (reset),
    .hold       (hold),
    .exec_req   (exec_req),
    .exec_ready (exec_ready),
    .status     (status)
);

// File: verification/timing_tb.sv
module timing_tb;
    import control_pkg::*;

    localparam int word_cycles = 56;

    logic           sim_clk;
    logic           reset;
    logic           hold;
    exec_req_t      exec_req;
    logic           exec_ready;
    timing_status_t status;

    logic [31:0] rng_state;
    int          tests_run;
    int          tests_failed;
    int          start_errors;
    bit          timed_out;

    tb_clock u_tb_clock (
        .sim_clk (sim_clk),
        .reset   (reset)
    );

    timing_top u_timing_top (
        .sim_clk    (sim_clk),
        .reset      (reset),
        .hold       (hold),
        .exec_req   (exec_req),
        .exec_ready (exec_ready),
        .status     (status)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] v;
        v = s ^ (s << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    // Inputs change and outputs are read 1 unit after the edge.
    task automatic next_cycle();
        @(posedge sim_clk);
        #1;
    endtask

    task automatic begin_test();
        start_errors = u_timing_top.u_timing_assertions.fail_count;
        timed_out    = 1'b0;
    endtask

    task automatic end_test(input string name);
        int errors;
        errors = u_timing_top.u_timing_assertions.fail_count - start_errors;
        tests_run++;
        if (errors != 0) begin
            $display("error at %0t: %s saw %0d assertion failures", $time, name, errors);
        end
        if (errors != 0 || timed_out) begin
            tests_failed++;
            $display("test %s failed", name);
        end else begin
            $display("test %s passed", name);
        end
    endtask

    task automatic wait_reset_release();
        int count;
        count = 0;
        while (reset && count < 10) begin
            next_cycle();
            count++;
        end
        if (reset) begin
            timed_out = 1'b1;
            $display("timeout while waiting for reset to be released");
        end
    endtask

    task automatic wait_word_done(input string name);
        int count;
        count = 0;
        while (!status.word_done && count < word_cycles + 4) begin
            next_cycle();
            count++;
        end
        if (!status.word_done) begin
            timed_out = 1'b1;
            $display("timeout in %s while waiting for word_done", name);
        end
    endtask

    task automatic run_request(input string name);
        int count;
        rng_state = xorshift(rng_state);
        repeat (rng_state[4:0]) next_cycle();        // Random gap before the request.
        exec_req.valid   = 1'b1;
        exec_req.ccfh_in = rng_state[8];
        count = 0;
        while (!exec_ready && count < 3 * word_cycles) begin
            next_cycle();
            count++;
        end
        if (!exec_ready) begin
            timed_out = 1'b1;
            $display("timeout in %s while waiting for exec_ready", name);
        end
        next_cycle();
        exec_req.valid = 1'b0;
        count = 0;
        while (status.rec_state != rec_idle && count < 32) begin
            next_cycle();
            count++;
        end
        if (status.rec_state != rec_idle) begin
            timed_out = 1'b1;
            $display("timeout in %s while waiting for the record chain to go idle", name);
        end
    endtask

    initial begin
        hold         = 1'b0;
        exec_req     = '0;
        rng_state    = 32'h33f0ef03;
        tests_run    = 0;
        tests_failed = 0;

        begin_test();
        wait_reset_release();
        repeat (16) next_cycle();
        end_test("slot_sequence");

        begin_test();
        wait_word_done("gate_ring");
        next_cycle();
        wait_word_done("gate_ring");
        next_cycle();
        end_test("gate_ring");

        begin_test();
        for (int i = 0; i < 6; i++) begin
            rng_state = xorshift(rng_state);
            hold = (i == 1) || (rng_state[1:0] == 2'b00);
            wait_word_done("program_phase");
            next_cycle();
        end
        hold = 1'b0;
        end_test("program_phase");

        begin_test();
        run_request("exec_handshake");
        end_test("exec_handshake");

        begin_test();
        run_request("record_chain");
        end_test("record_chain");

        begin_test();
        repeat (5) run_request("ccfh_capture");
        end_test("ccfh_capture");

        $display("tests run %0d, passed %0d, failed %0d",
                 tests_run, tests_run - tests_failed, tests_failed);
        if (tests_failed == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule
